//--- Makefile
# Verilator flow for the file transfer engine

TB_TOP = tb_file_io

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module file_io_top

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TB_TOP) -o sim_$(TB_TOP)
	./obj_dir/sim_$(TB_TOP) | tee sim.log
	@grep -q ">>> PASS" sim.log || { echo "simulation failed"; exit 1; }

clean:
	rm -rf obj_dir sim.log

//--- dump_formatter.sv
`timescale 1ns/1ps
`default_nettype none

module dump_formatter (
  input  wire file_io_pkg::bank_t  bank_i,
  input  wire [8:0]                byte_cnt_i,
  input  wire [3:0]                row_pos_i,
  input  wire file_io_pkg::word_t  rd_word_i,
  output file_io_pkg::char_t       tx_byte_o
);

  file_io_pkg::nib_idx_t top_nib;   // msn of this bank's word
  file_io_pkg::nib_idx_t nib_sel;
  logic [3:0]            nib_val;

  // upper case hex only
  function automatic file_io_pkg::char_t hex_char(input logic [3:0] val);
    if (val < 4'd10)
      return {4'h3, val};
    else
      return 8'h37 + {4'h0, val};   // 10 -> 'A'
  endfunction

  // row position counts from the most significant nibble down
  assign top_nib = file_io_pkg::last_nib(bank_i);
  assign nib_sel = top_nib - row_pos_i[2:0];
  assign nib_val = rd_word_i[{nib_sel, 2'b00} +: 4];

  // ************************************************************
  // character select
  // ************************************************************
  always_comb
  begin
    if (byte_cnt_i < 9'd4)
    begin
      case (byte_cnt_i[1:0])            // header
        2'd0:    tx_byte_o = file_io_pkg::CH_SOH;
        2'd1:    tx_byte_o = hex_char(4'(bank_i));   // file name is the bank digit
        2'd2:    tx_byte_o = file_io_pkg::CH_EOT;
        default: tx_byte_o = file_io_pkg::CH_SOT;
      endcase
    end
    else if (row_pos_i == file_io_pkg::ROW_EOF)
      tx_byte_o = file_io_pkg::CH_EOF;
    else if (row_pos_i == file_io_pkg::ROW_CR)
      tx_byte_o = file_io_pkg::CH_CR;
    else if (row_pos_i == file_io_pkg::ROW_LF)
      tx_byte_o = file_io_pkg::CH_LF;
    else
      tx_byte_o = hex_char(nib_val);    // row content
  end

endmodule

`default_nettype wire

//--- file_io_config.svh
`ifndef FILE_IO_CONFIG_SVH
`define FILE_IO_CONFIG_SVH

// ************************************************************
// bank geometry
// ************************************************************

`define FIO_NUM_BANKS    2      // banks dumped in order 0..N-1

// bank 0, 32-bit words
`define FIO_NIBBLES0     8
`define FIO_DEPTH0       16

// bank 1, 8-bit words
`define FIO_NIBBLES1     2
`define FIO_DEPTH1       8

`define FIO_ADDR_W       4      // covers the deepest bank
`define FIO_MAX_NIBBLES  8      // widest bank

`endif

//--- file_io_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "file_io_config.svh"

module file_io_ctrl (
  input  wire                      clk_sys,
  input  wire                      rst_clk,
  input  wire                      load_req_i,
  input  wire                      dump_req_i,
  input  wire file_io_pkg::bank_t  load_bank_i,
  input  wire file_io_pkg::char_t  rx_byte_i,
  input  wire                      rx_valid_i,
  input  wire                      digit_ok_i,
  input  wire                      tx_full_i,
  output logic                     shift_en_o,
  output logic                     wr_en_o,
  output logic                     tx_we_o,
  output logic                     busy_o,
  output file_io_pkg::nib_idx_t    nib_idx_o,
  output file_io_pkg::bank_t       bank_o,
  output file_io_pkg::addr_t       addr_o,
  output logic [8:0]               byte_cnt_o,
  output logic [3:0]               row_pos_o
);

  localparam logic [1:0] ST_IDLE     = 2'd0;
  localparam logic [1:0] ST_WAIT_SOT = 2'd1;   // skip text up to SOT
  localparam logic [1:0] ST_LOAD     = 2'd2;
  localparam logic [1:0] ST_DUMP     = 2'd3;

  logic [1:0]            state_q;
  logic                  digit_take;   // hex digit accepted this cycle
  file_io_pkg::nib_idx_t nib_last;
  file_io_pkg::addr_t    addr_last;

  assign nib_last  = file_io_pkg::last_nib(bank_o);
  assign addr_last = (bank_o == file_io_pkg::bank_t'(1)) ?
                     file_io_pkg::addr_t'(`FIO_DEPTH1 - 1) :
                     file_io_pkg::addr_t'(`FIO_DEPTH0 - 1);

  assign digit_take = (state_q == ST_LOAD) && rx_valid_i && digit_ok_i;
  assign shift_en_o = digit_take;
  assign wr_en_o    = digit_take && (nib_idx_o == '0);   // last nibble completes the word
  assign tx_we_o    = (state_q == ST_DUMP) && !tx_full_i;
  assign busy_o     = (state_q != ST_IDLE);

  // ************************************************************
  // state and counters
  // ************************************************************
  always_ff @(posedge clk_sys)
  begin
    if (rst_clk)
    begin
      state_q    <= ST_IDLE;
      bank_o     <= '0;
      addr_o     <= '0;
      nib_idx_o  <= '0;
      byte_cnt_o <= '0;
      row_pos_o  <= '0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          if (dump_req_i)                // dump wins over load
          begin
            state_q    <= ST_DUMP;
            bank_o     <= '0;
            addr_o     <= '0;           // read of row 0 overlaps the header
            byte_cnt_o <= '0;
            row_pos_o  <= '0;
          end
          else if (load_req_i)
          begin
            state_q <= ST_WAIT_SOT;
            bank_o  <= load_bank_i;
          end
        end
        ST_WAIT_SOT:
        begin
          if (rx_valid_i && (rx_byte_i == file_io_pkg::CH_SOT))
          begin
            state_q   <= ST_LOAD;
            addr_o    <= '0;
            nib_idx_o <= nib_last;      // msn arrives first
          end
        end
        ST_LOAD:
        begin
          if (digit_take)
          begin
            if (nib_idx_o == '0)
            begin
              nib_idx_o <= nib_last;
              if (addr_o == addr_last)   // bank full, load done
              begin
                state_q <= ST_IDLE;
                addr_o  <= '0;
              end
              else
                addr_o <= addr_o + 1'b1;
            end
            else
              nib_idx_o <= nib_idx_o - 1'b1;
          end
        end
        ST_DUMP:
        begin
          if (tx_we_o)                   // everything holds under back-pressure
          begin
            if (row_pos_o == file_io_pkg::ROW_EOF)
            begin
              byte_cnt_o <= '0;
              row_pos_o  <= '0;
              if (bank_o == file_io_pkg::bank_t'(`FIO_NUM_BANKS - 1))
                state_q <= ST_IDLE;
              else
                bank_o <= bank_o + 1'b1;
            end
            else
            begin
              byte_cnt_o <= byte_cnt_o + 1'b1;
              if (byte_cnt_o >= 9'd4)    // header bytes leave row_pos at 0
              begin
                if (row_pos_o == file_io_pkg::ROW_CR)
                begin
                  row_pos_o <= file_io_pkg::ROW_LF;
                  // next address during CR, ram needs a cycle
                  addr_o    <= (addr_o == addr_last) ? '0 : addr_o + 1'b1;
                end
                else if (row_pos_o == file_io_pkg::ROW_LF)
                  // wrapped address marks the last row
                  row_pos_o <= (addr_o == '0) ? file_io_pkg::ROW_EOF : 4'h0;
                else if (row_pos_o[2:0] == nib_last)
                  row_pos_o <= file_io_pkg::ROW_CR;
                else
                  row_pos_o <= row_pos_o + 1'b1;
              end
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- file_io_pkg.sv
`default_nettype none

`include "file_io_config.svh"

package file_io_pkg;

  typedef logic [$clog2(`FIO_NUM_BANKS)-1:0]   bank_t;
  typedef logic [`FIO_ADDR_W-1:0]              addr_t;
  typedef logic [4*`FIO_MAX_NIBBLES-1:0]       word_t;    // narrow banks use low bits
  typedef logic [$clog2(`FIO_MAX_NIBBLES)-1:0] nib_idx_t;
  typedef logic [7:0]                          char_t;

  // framing characters of the text file
  localparam char_t CH_SOH = 8'h01;
  localparam char_t CH_SOT = 8'h02;
  localparam char_t CH_EOT = 8'h03;
  localparam char_t CH_EOF = 8'h04;
  localparam char_t CH_LF  = 8'h0a;
  localparam char_t CH_CR  = 8'h0d;

  // row position codes above the nibble range
  localparam logic [3:0] ROW_CR  = 4'h8;
  localparam logic [3:0] ROW_LF  = 4'h9;
  localparam logic [3:0] ROW_EOF = 4'ha;   // row after the last LF

  // index of the most significant nibble of a bank's word
  function automatic nib_idx_t last_nib(input bank_t bank);
    return (bank == bank_t'(1)) ? nib_idx_t'(`FIO_NIBBLES1 - 1)
                                : nib_idx_t'(`FIO_NIBBLES0 - 1);
  endfunction

endpackage

`default_nettype wire

//--- file_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module file_io_top (
  input  wire                      clk_sys,
  input  wire                      rst_clk,
  input  wire                      load_req_i,    // load pulse, bank on load_bank_i
  input  wire file_io_pkg::bank_t  load_bank_i,
  input  wire                      dump_req_i,    // dump all banks
  input  wire file_io_pkg::char_t  rx_byte_i,
  input  wire                      rx_valid_i,
  input  wire                      tx_full_i,
  output file_io_pkg::char_t       tx_byte_o,
  output logic                     tx_we_o,
  output logic                     busy_o
);

  logic                  digit_ok;
  logic                  shift_en;
  logic                  wr_en;
  file_io_pkg::nib_idx_t nib_idx;
  file_io_pkg::bank_t    bank;
  file_io_pkg::addr_t    addr;
  logic [8:0]            byte_cnt;
  logic [3:0]            row_pos;
  file_io_pkg::word_t    wr_word;   // assembled word, combinational
  file_io_pkg::word_t    rd_word;   // one cycle after addr

  file_io_ctrl ctrl_i (
    .clk_sys     (clk_sys),
    .rst_clk     (rst_clk),
    .load_req_i  (load_req_i),
    .dump_req_i  (dump_req_i),
    .load_bank_i (load_bank_i),
    .rx_byte_i   (rx_byte_i),
    .rx_valid_i  (rx_valid_i),
    .digit_ok_i  (digit_ok),
    .tx_full_i   (tx_full_i),
    .shift_en_o  (shift_en),
    .wr_en_o     (wr_en),
    .tx_we_o     (tx_we_o),
    .busy_o      (busy_o),
    .nib_idx_o   (nib_idx),
    .bank_o      (bank),
    .addr_o      (addr),
    .byte_cnt_o  (byte_cnt),
    .row_pos_o   (row_pos)
  );

  nibble_assembler nib_asm_i (
    .clk_sys    (clk_sys),
    .rst_clk    (rst_clk),
    .rx_byte_i  (rx_byte_i),
    .shift_en_i (shift_en),
    .nib_idx_i  (nib_idx),
    .digit_ok_o (digit_ok),
    .word_o     (wr_word)
  );

  mem_banks mem_i (
    .clk_sys   (clk_sys),
    .bank_i    (bank),
    .addr_i    (addr),
    .wr_en_i   (wr_en),
    .wr_word_i (wr_word),
    .rd_word_o (rd_word)
  );

  dump_formatter fmt_i (
    .bank_i     (bank),
    .byte_cnt_i (byte_cnt),
    .row_pos_i  (row_pos),
    .rd_word_i  (rd_word),
    .tx_byte_o  (tx_byte_o)
  );

endmodule

`default_nettype wire

//--- mem_banks.sv
`timescale 1ns/1ps
`default_nettype none

`include "file_io_config.svh"

module mem_banks (
  input  wire                      clk_sys,
  input  wire file_io_pkg::bank_t  bank_i,
  input  wire file_io_pkg::addr_t  addr_i,
  input  wire                      wr_en_i,
  input  wire file_io_pkg::word_t  wr_word_i,
  output file_io_pkg::word_t       rd_word_o
);

  localparam int W0   = 4 * `FIO_NIBBLES0;
  localparam int W1   = 4 * `FIO_NIBBLES1;
  localparam int A1_W = $clog2(`FIO_DEPTH1);   // bank 1 is shallower

  logic [W0-1:0]      ram0 [`FIO_DEPTH0];
  logic [W1-1:0]      ram1 [`FIO_DEPTH1];
  logic [W0-1:0]      rd0_q;
  logic [W1-1:0]      rd1_q;
  file_io_pkg::bank_t bank_q;   // bank of the data in the read registers

  // bank 0, 32-bit words
  always_ff @(posedge clk_sys)
  begin
    if (wr_en_i && (bank_i == file_io_pkg::bank_t'(0)))
      ram0[addr_i] <= wr_word_i[W0-1:0];
    rd0_q <= ram0[addr_i];
  end

  // bank 1, 8-bit words
  always_ff @(posedge clk_sys)
  begin
    if (wr_en_i && (bank_i == file_io_pkg::bank_t'(1)))
      ram1[addr_i[A1_W-1:0]] <= wr_word_i[W1-1:0];
    rd1_q <= ram1[addr_i[A1_W-1:0]];
  end

  always_ff @(posedge clk_sys)
  begin
    bank_q <= bank_i;
  end

  // read mux after the registers, narrow bank zero extended
  assign rd_word_o = (bank_q == file_io_pkg::bank_t'(1)) ? file_io_pkg::word_t'(rd1_q)
                                                         : file_io_pkg::word_t'(rd0_q);

endmodule

`default_nettype wire

//--- nibble_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module nibble_assembler (
  input  wire                         clk_sys,
  input  wire                         rst_clk,
  input  wire file_io_pkg::char_t     rx_byte_i,
  input  wire                         shift_en_i,
  input  wire file_io_pkg::nib_idx_t  nib_idx_i,
  output logic                        digit_ok_o,
  output file_io_pkg::word_t          word_o
);

  logic [3:0]         nib_val;   // decoded digit
  file_io_pkg::word_t word_q;    // nibbles collected so far

  // hex decode in either case
  always_comb
  begin
    digit_ok_o = 1'b1;
    nib_val    = 4'h0;
    if ((rx_byte_i >= 8'h30) && (rx_byte_i <= 8'h39))       // '0'..'9'
      nib_val = rx_byte_i[3:0];
    else if (((rx_byte_i >= 8'h41) && (rx_byte_i <= 8'h46)) ||   // A-F
             ((rx_byte_i >= 8'h61) && (rx_byte_i <= 8'h66)))     // a-f
      nib_val = rx_byte_i[3:0] + 4'd9;                      // 1..6 -> 10..15
    else
      digit_ok_o = 1'b0;                                    // separator or garbage
  end

  // current digit merged in so the ram sees the full word on the last nibble
  always_comb
  begin
    word_o = word_q;
    if (shift_en_i)
      word_o[{nib_idx_i, 2'b00} +: 4] = nib_val;
  end

  always_ff @(posedge clk_sys)
  begin
    if (rst_clk)
      word_q <= '0;
    else if (shift_en_i)
      word_q <= word_o;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
file_io_pkg.sv
nibble_assembler.sv
dump_formatter.sv
mem_banks.sv
file_io_ctrl.sv
file_io_top.sv
tb_clk_gen.sv
tb_file_io.sv

//--- tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_sys,
  output logic rst_clk
);

  localparam int HALF_NS = 4;   // 8 ns period

  initial
  begin
    clk_sys = 1'b0;
    forever #HALF_NS clk_sys = ~clk_sys;
  end

  // reset held over the first three rising edges
  initial
  begin
    rst_clk <= 1'b1;
    repeat (3) @(posedge clk_sys);
    rst_clk <= 1'b0;
  end

endmodule

`default_nettype wire

//--- tb_file_io.sv
`timescale 1ns/1ps
`default_nettype none

`include "file_io_config.svh"

module tb_file_io;

  // ************************************************************
  // test lengths and watchdog
  // ************************************************************
  localparam int CLK_NS       = 8;
  localparam int BANK0_BYTES  = 5 + `FIO_DEPTH0 * (`FIO_NIBBLES0 + 2);
  localparam int BANK1_BYTES  = 5 + `FIO_DEPTH1 * (`FIO_NIBBLES1 + 2);
  localparam int DUMP_BYTES   = BANK0_BYTES + BANK1_BYTES;
  localparam int LOAD0_CHARS  = 1 + `FIO_DEPTH0 * (`FIO_NIBBLES0 + 2);
  localparam int LOAD1_CHARS  = 1 + `FIO_DEPTH1 * (`FIO_NIBBLES1 + 2);
  localparam int MESSY0_CHARS = 9 + `FIO_DEPTH0 * `FIO_NIBBLES0 * 4;   // up to 3 separators
  localparam int TOTAL_BYTES  = 4 * DUMP_BYTES + LOAD0_CHARS + 2 * LOAD1_CHARS + MESSY0_CHARS;
  localparam int WATCHDOG_CYC = 4 * TOTAL_BYTES + 1000;

  logic               clk_sys;
  logic               rst_clk;
  logic               load_req_i = 1'b0;
  file_io_pkg::bank_t load_bank_i = '0;
  logic               dump_req_i = 1'b0;
  file_io_pkg::char_t rx_byte_i = '0;
  logic               rx_valid_i = 1'b0;
  logic               tx_full_i = 1'b0;
  file_io_pkg::char_t tx_byte_o;
  logic               tx_we_o;
  logic               busy_o;

  // reference model of the banks
  logic [4*`FIO_NIBBLES0-1:0] mem0 [`FIO_DEPTH0];
  logic [4*`FIO_NIBBLES1-1:0] mem1 [`FIO_DEPTH1];
  logic [7:0]  exp_q [$];                 // bytes still expected from the dump
  logic [7:0]  exp_b;
  logic [31:0] lfsr = 32'h3fe0_06ff;
  string       hex_up = "0123456789ABCDEF";
  string       hex_lo = "0123456789abcdef";
  int          err_main = 0;              // failures seen by the stimulus process
  int          err_chk = 0;               // failures seen by the byte checker
  int          sent_cnt = 0;
  int          test_cnt = 0;

  tb_clk_gen clk_gen_i (
    .clk_sys (clk_sys),
    .rst_clk (rst_clk)
  );

  file_io_top dut_i (
    .clk_sys     (clk_sys),
    .rst_clk     (rst_clk),
    .load_req_i  (load_req_i),
    .load_bank_i (load_bank_i),
    .dump_req_i  (dump_req_i),
    .rx_byte_i   (rx_byte_i),
    .rx_valid_i  (rx_valid_i),
    .tx_full_i   (tx_full_i),
    .tx_byte_o   (tx_byte_o),
    .tx_we_o     (tx_we_o),
    .busy_o      (busy_o)
  );

  // galois lfsr stepped once per bit
  function automatic logic rand_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b)
      lfsr = lfsr ^ 32'h8020_0003;
    return b;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], rand_bit()};
    return v;
  endfunction

  function automatic bit is_hex(input logic [7:0] c);
    return ((c >= 8'h30) && (c <= 8'h39)) || ((c >= 8'h41) && (c <= 8'h46)) ||
           ((c >= 8'h61) && (c <= 8'h66));
  endfunction

  function automatic logic [7:0] sep_char();
    logic [7:0] c;
    do
      c = 8'(rand_bits(8));
    while (is_hex(c));
    return c;
  endfunction

  // expected bytes of one bank in send order
  function automatic void push_bank(input int b);
    int          depth;
    int          nibs;
    logic [31:0] w;
    depth = (b == 0) ? `FIO_DEPTH0 : `FIO_DEPTH1;
    nibs  = (b == 0) ? `FIO_NIBBLES0 : `FIO_NIBBLES1;
    exp_q.push_back(8'h01);                           // SOH
    exp_q.push_back(hex_up[b]);                       // bank digit
    exp_q.push_back(8'h03);                           // EOT
    exp_q.push_back(8'h02);                           // SOT
    for (int a = 0; a < depth; a++)
    begin
      w = (b == 0) ? 32'(mem0[a]) : 32'(mem1[a]);
      for (int n = nibs - 1; n >= 0; n--)
        exp_q.push_back(hex_up[int'(w[4*n +: 4])]);
      exp_q.push_back(8'h0d);
      exp_q.push_back(8'h0a);
    end
    exp_q.push_back(8'h04);                           // EOF
  endfunction

  task automatic wait_idle(input int limit, input string what);
    int cyc;
    cyc = 0;
    while (busy_o && (cyc <= limit))
    begin
      @(posedge clk_sys);
      cyc++;
    end
    if (busy_o)
    begin
      $display("%s did not finish, busy_o stuck high", what);
      err_main++;
    end
  endtask

  // one strobe after 0 or 1 idle cycles with optional stray requests
  task automatic send_char(input logic [7:0] c, input bit poke);
    repeat (rand_bits(1)) @(posedge clk_sys);
    @(posedge clk_sys);
    rx_byte_i  <= c;
    rx_valid_i <= 1'b1;
    if (poke)
    begin
      dump_req_i  <= rand_bit();   // dut is busy and must ignore these
      load_req_i  <= rand_bit();
      load_bank_i <= rand_bit();
    end
    @(posedge clk_sys);
    rx_valid_i <= 1'b0;
    dump_req_i <= 1'b0;
    load_req_i <= 1'b0;
  endtask

  task automatic load_bank(input int b, input bit messy, input bit poke);
    int          depth;
    int          nibs;
    logic [31:0] w;
    logic [7:0]  c;
    depth = (b == 0) ? `FIO_DEPTH0 : `FIO_DEPTH1;
    nibs  = (b == 0) ? `FIO_NIBBLES0 : `FIO_NIBBLES1;
    @(posedge clk_sys);
    load_req_i  <= 1'b1;
    load_bank_i <= b[0];
    @(posedge clk_sys);
    load_req_i  <= 1'b0;
    if (messy)
    begin
      repeat (1 + rand_bits(3))
      begin
        c = 8'(rand_bits(8));   // junk before SOT may include digits
        if (c == 8'h02)
          c = 8'h3f;
        send_char(c, poke);
      end
    end
    send_char(8'h02, poke);     // SOT
    for (int a = 0; a < depth; a++)
    begin
      w = 32'(rand_bits(4 * nibs));
      if (b == 0)
        mem0[a] = w;
      else
        mem1[a] = w[4*`FIO_NIBBLES1-1:0];
      for (int n = nibs - 1; n >= 0; n--)
      begin
        if (messy)
          repeat (rand_bits(2)) send_char(sep_char(), poke);
        if (messy && rand_bit())
          send_char(hex_lo[int'(w[4*n +: 4])], poke);
        else
          send_char(hex_up[int'(w[4*n +: 4])], poke);
      end
      if (!messy && (a != depth - 1))
      begin
        send_char(8'h0d, poke);   // CR LF between rows
        send_char(8'h0a, poke);
      end
    end
    wait_idle(8, "load");
  endtask

  task automatic run_dump(input bit bp, input bit poke);
    int cyc;
    int start_cnt;
    exp_q.delete();
    for (int b = 0; b < `FIO_NUM_BANKS; b++)
      push_bank(b);
    start_cnt = sent_cnt;
    @(posedge clk_sys);
    dump_req_i <= 1'b1;
    @(posedge clk_sys);
    dump_req_i <= 1'b0;
    cyc = 0;
    do
    begin
      @(posedge clk_sys);
      tx_full_i <= bp ? rand_bit() : 1'b0;
      if (poke && (cyc < DUMP_BYTES - 4))   // stay clear of the final EOF
      begin
        dump_req_i  <= rand_bit();
        load_req_i  <= rand_bit();
        load_bank_i <= rand_bit();
      end
      else
      begin
        dump_req_i <= 1'b0;
        load_req_i <= 1'b0;
      end
      cyc++;
    end
    while (busy_o && (cyc <= 8 * DUMP_BYTES));
    tx_full_i <= 1'b0;
    if (busy_o)
    begin
      $display("dump did not finish, busy_o stuck high");
      err_main++;
    end
    assert (exp_q.size() == 0)
    else
    begin
      $display("dump ended with %0d expected bytes never sent", exp_q.size());
      err_main++;
    end
    assert ((sent_cnt - start_cnt) == DUMP_BYTES)
    else
    begin
      $display("FAILED tx_we_o count got %h expected %h", sent_cnt - start_cnt, DUMP_BYTES);
      err_main++;
    end
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles)
    begin
      @(posedge clk_sys);
      assert (!busy_o && !tx_we_o)
      else
      begin
        $display("FAILED busy_o/tx_we_o got %h/%h expected 0/0", busy_o, tx_we_o);
        err_main++;
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    int errs;
    errs = err_main + err_chk - errs_before;
    test_cnt++;
    if (errs == 0)
      $display("test %0d %s: ok", test_cnt, name);
    else
      $display("test %0d %s: %0d errors", test_cnt, name, errs);
  endtask

  // ************************************************************
  // byte checker sampled on the rising edge
  // ************************************************************
  always @(posedge clk_sys)
  begin
    if (!rst_clk)
    begin
      assert (!(tx_we_o && tx_full_i))
      else
      begin
        $display("FAILED tx_we_o got %h expected 0 while tx_full_i high", tx_we_o);
        err_chk++;
      end
      if (tx_we_o)
      begin
        sent_cnt++;
        assert (exp_q.size() > 0)
        else
        begin
          $display("byte %h was sent while no byte was expected", tx_byte_o);
          err_chk++;
        end
        if (exp_q.size() > 0)
        begin
          exp_b = exp_q.pop_front();
          assert (tx_byte_o == exp_b)
          else
          begin
            $display("FAILED tx_byte_o got %h expected %h", tx_byte_o, exp_b);
            err_chk++;
          end
        end
      end
    end
  end

  initial
  begin
    #(WATCHDOG_CYC * CLK_NS);
    $display("watchdog expired before the tests finished");
    $display(">>> FAIL");
    $finish;
  end

  // ************************************************************
  // test sequence
  // ************************************************************
  initial
  begin
    int e0;
    do
      @(posedge clk_sys);
    while (rst_clk);

    e0 = err_main + err_chk;
    check_idle(20);
    report_test("idle after reset", e0);

    e0 = err_main + err_chk;
    load_bank(0, 1'b0, 1'b0);
    load_bank(1, 1'b0, 1'b0);
    run_dump(1'b0, 1'b0);
    report_test("load both banks and dump", e0);

    e0 = err_main + err_chk;
    load_bank(0, 1'b1, 1'b0);   // junk with lower case digits and separators
    run_dump(1'b0, 1'b0);
    report_test("noisy load", e0);

    e0 = err_main + err_chk;
    run_dump(1'b1, 1'b0);
    report_test("dump under back-pressure", e0);

    e0 = err_main + err_chk;
    load_bank(1, 1'b0, 1'b1);
    run_dump(1'b0, 1'b1);
    report_test("requests while busy", e0);

    $display("tests %0d, byte checks %0d, errors %0d", test_cnt, sent_cnt,
             err_main + err_chk);
    if ((err_main + err_chk) == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire
